/* sd_card_model.sv */
// SPI-mode SD card model that decodes command frames, answers them and serves block data
`default_nettype none

module sd_card_model (
   input  wire logic       reset_i,
   input  wire logic       ss_i,
   input  wire logic       sclk_i,
   input  wire logic       mosi_i,
   input  wire logic [7:0] acmd41_busy_i,
   output logic            miso_o = 1'b1
);
   import sd_proto_pkg::*;

   sd_frame_t   frames[$];
   logic [7:0]  resp_q[$];
   int          init_clks = 0;
   int          acmd41_tries = 0;
   int          frame_len = 0;
   logic [2:0]  bit_cnt = 3'd0;
   logic [7:0]  rx_sh;
   logic [7:0]  tx_sh = 8'hFF;
   logic [47:0] frame_sh;

   // one filler byte ahead of every R1
   task automatic push_r1(input logic [7:0] r1);
      resp_q.push_back(8'hFF);
      resp_q.push_back(r1);
   endtask

   task automatic answer(input sd_frame_t f);
      logic [31:0] val;
      case (f.idx)
         CMD_SEND_IF_COND:
         begin
            push_r1(R1_IDLE);
            resp_q.push_back(8'h00);
            resp_q.push_back(8'h00);
            resp_q.push_back(8'h01);
            resp_q.push_back(8'hAA);
         end
         ACMD_SEND_OP_COND:
            if (acmd41_tries < int'(acmd41_busy_i))
            begin
               acmd41_tries++;
               push_r1(R1_IDLE);
            end
            else
               push_r1(R1_READY);
         CMD_READ_SINGLE:
         begin
            push_r1(R1_READY);
            // a short access delay before the start token
            resp_q.push_back(8'hFF);
            resp_q.push_back(8'hFF);
            resp_q.push_back(TOKEN_START_BLOCK);
            for (int i = 0; i < BLOCK_BYTES; i++)
            begin
               val = f.arg * 32'd7 + 32'(i) * 32'd13;
               resp_q.push_back(val[7:0]);
            end
            resp_q.push_back(8'hA5);
            resp_q.push_back(8'h5A);
         end
         default:
            push_r1(R1_IDLE);
      endcase
   endtask

   task automatic take_byte(input logic [7:0] b);
      if (frame_len == 0)
      begin
         if (b[7:6] == 2'b01)
         begin
            frame_sh  = {40'd0, b};
            frame_len = 1;
         end
      end
      else
      begin
         frame_sh = {frame_sh[39:0], b};
         frame_len++;
         if (frame_len == 6)
         begin
            frames.push_back(sd_frame_t'(frame_sh));
            answer(sd_frame_t'(frame_sh));
            frame_len = 0;
         end
      end
   endtask

   // mode 0: sample mosi on the rising edge, shift miso on the falling edge
   always @(posedge sclk_i or negedge sclk_i or posedge reset_i)
   begin
      if (reset_i)
      begin
         frames.delete();
         resp_q.delete();
         init_clks    = 0;
         acmd41_tries = 0;
         frame_len    = 0;
         bit_cnt      = 3'd0;
         tx_sh        = 8'hFF;
         miso_o      <= 1'b1;
      end
      else if (ss_i)
      begin
         bit_cnt = 3'd0;
         miso_o <= 1'b1;
         if (sclk_i && mosi_i)
            init_clks++;
      end
      else if (sclk_i)
      begin
         rx_sh   = {rx_sh[6:0], mosi_i};
         bit_cnt = bit_cnt + 3'd1;
         if (bit_cnt == 3'd0)
            take_byte(rx_sh);
      end
      else
      begin
         if (bit_cnt == 3'd0)
            tx_sh = (resp_q.size() > 0) ? resp_q.pop_front() : 8'hFF;
         miso_o <= tx_sh[7];
         tx_sh   = {tx_sh[6:0], 1'b1};
      end
   end

endmodule

`default_nettype wire

/* sd_cmd_engine.sv */
// SD command engine: sends a 6-byte frame, polls for R1 and reads the trailing bytes
`default_nettype none

module sd_cmd_engine #(
   parameter int RESP_POLL_LIMIT = 8
) (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  start_i,
   input  wire sd_host_pkg::cmd_req_t req_i,
   output logic                       done_o,
   output sd_host_pkg::byte_t         r1_o,
   output logic [31:0]                trailer_o,
   output logic                       spi_start_o,
   output sd_host_pkg::byte_t         spi_tx_o,
   input  wire logic                  spi_done_i,
   input  wire sd_host_pkg::byte_t    spi_rx_i
);
   import sd_host_pkg::*;
   import sd_proto_pkg::*;

   typedef enum logic [1:0] {
      CE_IDLE,
      CE_SEND,
      CE_POLL,
      CE_TRAIL
   } ce_state_t;

   ce_state_t   state;
   sd_frame_t   frame;
   logic [55:0] tx_sh;
   logic [7:0]  cnt;
   logic [2:0]  resp_len;

   assign frame = '{start: FRAME_START, idx: req_i.idx, arg: req_i.arg, crc: req_i.crc};
   assign spi_tx_o = tx_sh[55:48];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= CE_IDLE;
         cnt         <= '0;
         done_o      <= 1'b0;
         spi_start_o <= 1'b0;
      end
      else
      begin
         done_o      <= 1'b0;
         spi_start_o <= 1'b0;
         case (state)
            CE_IDLE:
               if (start_i)
               begin
                  // one filler byte ahead of the frame
                  tx_sh       <= {8'hFF, frame};
                  resp_len    <= req_i.resp_len;
                  cnt         <= '0;
                  spi_start_o <= 1'b1;
                  state       <= CE_SEND;
               end
            CE_SEND:
               if (spi_done_i)
               begin
                  tx_sh       <= {tx_sh[47:0], 8'hFF};
                  spi_start_o <= 1'b1;
                  if (cnt == 8'd6)
                  begin
                     cnt   <= '0;
                     state <= CE_POLL;
                  end
                  else
                  begin
                     cnt <= cnt + 8'd1;
                  end
               end
            CE_POLL:
               if (spi_done_i)
               begin
                  if (!spi_rx_i[7])
                  begin
                     r1_o <= spi_rx_i;
                     cnt  <= '0;
                     if (resp_len == 3'd0)
                     begin
                        done_o <= 1'b1;
                        state  <= CE_IDLE;
                     end
                     else
                     begin
                        spi_start_o <= 1'b1;
                        state       <= CE_TRAIL;
                     end
                  end
                  else if (cnt == 8'(RESP_POLL_LIMIT - 1))
                  begin
                     // no response from the card
                     r1_o   <= 8'hFF;
                     done_o <= 1'b1;
                     state  <= CE_IDLE;
                  end
                  else
                  begin
                     cnt         <= cnt + 8'd1;
                     spi_start_o <= 1'b1;
                  end
               end
            CE_TRAIL:
               if (spi_done_i)
               begin
                  trailer_o <= {trailer_o[23:0], spi_rx_i};
                  if (cnt == {5'd0, resp_len} - 8'd1)
                  begin
                     done_o <= 1'b1;
                     state  <= CE_IDLE;
                  end
                  else
                  begin
                     cnt         <= cnt + 8'd1;
                     spi_start_o <= 1'b1;
                  end
               end
            default:
               state <= CE_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* sd_host_ctrl.sv */
// SD host sequencer: power-up, card identification and single-block read with host handshake
`default_nettype none

module sd_host_ctrl #(
   parameter int                      POWERUP_CYCLES = 25_000_000,
   parameter sd_host_pkg::sclk_div_t  INIT_DIV       = 5'd31,
   parameter int                      ACMD41_RETRIES = 255
) (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   r_block_i,
   input  wire logic                   r_byte_i,
   input  wire sd_host_pkg::blk_addr_t block_addr_i,
   input  wire sd_host_pkg::sclk_div_t sclk_div_i,
   output logic                        busy_o,
   output logic                        err_o,
   output logic                        byte_valid_o,
   output sd_host_pkg::byte_t          data_o,
   output logic                        ss_o,
   output logic                        spi_start_o,
   output sd_host_pkg::byte_t          spi_tx_o,
   output sd_host_pkg::sclk_div_t      spi_div_o,
   input  wire logic                   spi_done_i,
   input  wire sd_host_pkg::byte_t     spi_rx_i,
   output logic                        cmd_start_o,
   output sd_host_pkg::cmd_req_t       cmd_req_o,
   input  wire logic                   cmd_done_i,
   input  wire sd_host_pkg::byte_t     cmd_r1_i,
   input  wire logic                   cmd_spi_start_i,
   input  wire sd_host_pkg::byte_t     cmd_spi_tx_i,
   output logic                        cmd_spi_done_o,
   output sd_host_pkg::byte_t          cmd_spi_rx_o
);
   import sd_host_pkg::*;
   import sd_proto_pkg::*;

   ctrl_state_t state;
   logic [31:0] cnt;
   logic        own_start;
   logic        cmd_mode;
   blk_addr_t   addr_q;
   byte_t       data_q;
   sclk_div_t   div_q;

   // command engine owns the byte port during command states
   assign cmd_mode       = state inside {ST_CMD0, ST_CMD8, ST_CMD55, ST_ACMD41, ST_CMD17};
   assign spi_start_o    = cmd_mode ? cmd_spi_start_i : own_start;
   assign spi_tx_o       = cmd_mode ? cmd_spi_tx_i : 8'hFF;
   assign spi_div_o      = div_q;
   assign cmd_spi_done_o = cmd_mode & spi_done_i;
   assign cmd_spi_rx_o   = spi_rx_i;

   assign ss_o         = state inside {ST_POWERUP, ST_IDLE_CLKS, ST_ERROR};
   assign busy_o       = !(state inside {ST_IDLE, ST_BYTE_READY});
   assign err_o        = (state == ST_ERROR);
   assign byte_valid_o = (state == ST_BYTE_READY);
   assign data_o       = data_q;

   always_comb
   begin
      cmd_req_o = '{idx: CMD_GO_IDLE, arg: 32'd0, crc: CRC_CMD0, resp_len: 3'd0};
      case (state)
         ST_CMD8:
            cmd_req_o = '{idx: CMD_SEND_IF_COND, arg: ARG_IF_COND, crc: CRC_CMD8,
                          resp_len: 3'd4};
         ST_CMD55:
            cmd_req_o = '{idx: CMD_APP, arg: 32'd0, crc: CRC_DUMMY, resp_len: 3'd0};
         ST_ACMD41:
            cmd_req_o = '{idx: ACMD_SEND_OP_COND, arg: ARG_HCS, crc: CRC_DUMMY,
                          resp_len: 3'd0};
         ST_CMD17:
            cmd_req_o = '{idx: CMD_READ_SINGLE, arg: addr_q, crc: CRC_DUMMY, resp_len: 3'd0};
         default:
            cmd_req_o = '{idx: CMD_GO_IDLE, arg: 32'd0, crc: CRC_CMD0, resp_len: 3'd0};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= ST_POWERUP;
         cnt         <= '0;
         own_start   <= 1'b0;
         cmd_start_o <= 1'b0;
         div_q       <= INIT_DIV;
      end
      else
      begin
         own_start   <= 1'b0;
         cmd_start_o <= 1'b0;
         case (state)
            ST_POWERUP:
               if (cnt == POWERUP_CYCLES - 1)
               begin
                  cnt       <= '0;
                  own_start <= 1'b1;
                  state     <= ST_IDLE_CLKS;
               end
               else
               begin
                  cnt <= cnt + 32'd1;
               end
            ST_IDLE_CLKS:
               if (spi_done_i)
               begin
                  if (cnt == INIT_CLK_BYTES - 1)
                  begin
                     cmd_start_o <= 1'b1;
                     state       <= ST_CMD0;
                  end
                  else
                  begin
                     cnt       <= cnt + 32'd1;
                     own_start <= 1'b1;
                  end
               end
            ST_CMD0:
               if (cmd_done_i)
               begin
                  // repeat CMD0 until the card reports idle
                  cmd_start_o <= 1'b1;
                  if (cmd_r1_i == R1_IDLE)
                     state <= ST_CMD8;
               end
            ST_CMD8:
               if (cmd_done_i)
               begin
                  cnt         <= '0;
                  cmd_start_o <= (cmd_r1_i == R1_IDLE);
                  state       <= (cmd_r1_i == R1_IDLE) ? ST_CMD55 : ST_ERROR;
               end
            ST_CMD55:
               if (cmd_done_i)
               begin
                  cmd_start_o <= (cmd_r1_i == R1_IDLE);
                  state       <= (cmd_r1_i == R1_IDLE) ? ST_ACMD41 : ST_ERROR;
               end
            ST_ACMD41:
               if (cmd_done_i)
               begin
                  if (cmd_r1_i == R1_READY)
                  begin
                     div_q <= sclk_div_i;
                     state <= ST_IDLE;
                  end
                  else if (cnt == ACMD41_RETRIES - 1)
                  begin
                     state <= ST_ERROR;
                  end
                  else
                  begin
                     cnt         <= cnt + 32'd1;
                     cmd_start_o <= 1'b1;
                     state       <= ST_CMD55;
                  end
               end
            ST_IDLE:
               if (r_block_i)
               begin
                  addr_q      <= block_addr_i;
                  cnt         <= '0;
                  cmd_start_o <= 1'b1;
                  state       <= ST_CMD17;
               end
            ST_CMD17:
               if (cmd_done_i)
               begin
                  own_start <= (cmd_r1_i == R1_READY);
                  state     <= (cmd_r1_i == R1_READY) ? ST_TOKEN : ST_ERROR;
               end
            ST_TOKEN:
               if (spi_done_i)
               begin
                  own_start <= 1'b1;
                  if (spi_rx_i == TOKEN_START_BLOCK)
                     state <= ST_BYTE_FETCH;
               end
            ST_BYTE_FETCH:
               if (spi_done_i)
               begin
                  data_q <= spi_rx_i;
                  state  <= ST_BYTE_READY;
               end
            ST_BYTE_READY:
               if (r_byte_i)
               begin
                  own_start <= 1'b1;
                  if (cnt == BLOCK_BYTES - 1)
                  begin
                     cnt   <= '0;
                     state <= ST_CRC;
                  end
                  else
                  begin
                     cnt   <= cnt + 32'd1;
                     state <= ST_BYTE_FETCH;
                  end
               end
            ST_CRC:
               if (spi_done_i)
               begin
                  if (cnt == CRC_BYTES - 1)
                  begin
                     state <= ST_IDLE;
                  end
                  else
                  begin
                     cnt       <= cnt + 32'd1;
                     own_start <= 1'b1;
                  end
               end
            ST_ERROR:
               state <= ST_ERROR;
            default:
               state <= ST_ERROR;
         endcase
      end
   end

endmodule

`default_nettype wire

/* sd_host_pkg.sv */
// host-side types for the SD SPI host: data widths, controller states and command requests
`default_nettype none

package sd_host_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [31:0] blk_addr_t;

   // sclk half period is div + 1 clk cycles
   typedef logic [4:0]  sclk_div_t;

   typedef enum logic [3:0] {
      ST_POWERUP,
      ST_IDLE_CLKS,
      ST_CMD0,
      ST_CMD8,
      ST_CMD55,
      ST_ACMD41,
      ST_IDLE,
      ST_CMD17,
      ST_TOKEN,
      ST_BYTE_FETCH,
      ST_BYTE_READY,
      ST_CRC,
      ST_ERROR
   } ctrl_state_t;

   // resp_len counts bytes after R1, either 0 or 4
   typedef struct packed {
      sd_proto_pkg::sd_cmd_idx_t idx;
      logic [31:0]               arg;
      byte_t                     crc;
      logic [2:0]                resp_len;
   } cmd_req_t;

endpackage

`default_nettype wire

/* sd_proto_pkg.sv */
// SD protocol constants for SPI mode: command indices, tokens, R1 codes and frame layout
`default_nettype none

package sd_proto_pkg;

   typedef logic [5:0] sd_cmd_idx_t;

   localparam sd_cmd_idx_t CMD_GO_IDLE       = 6'd0;
   localparam sd_cmd_idx_t CMD_SEND_IF_COND  = 6'd8;
   localparam sd_cmd_idx_t CMD_READ_SINGLE   = 6'd17;
   localparam sd_cmd_idx_t ACMD_SEND_OP_COND = 6'd41;
   localparam sd_cmd_idx_t CMD_APP           = 6'd55;

   // only CMD0 and CMD8 are crc-checked by the card in spi mode
   localparam logic [7:0] CRC_CMD0  = 8'h95;
   localparam logic [7:0] CRC_CMD8  = 8'h87;
   localparam logic [7:0] CRC_DUMMY = 8'h01;

   localparam logic [31:0] ARG_IF_COND = 32'h0000_01AA;
   localparam logic [31:0] ARG_HCS     = 32'h4000_0000;

   localparam logic [7:0] R1_IDLE  = 8'h01;
   localparam logic [7:0] R1_READY = 8'h00;

   localparam logic [7:0] TOKEN_START_BLOCK = 8'hFE;

   localparam int BLOCK_BYTES = 512;
   localparam int CRC_BYTES   = 2;

   // 80 clocks with MOSI high before the first command
   localparam int INIT_CLK_BYTES = 10;

   localparam logic [1:0] FRAME_START = 2'b01;

   typedef struct packed {
      logic [1:0]  start;
      sd_cmd_idx_t idx;
      logic [31:0] arg;
      logic [7:0]  crc;
   } sd_frame_t;

endpackage

`default_nettype wire

/* sd_spi_host.f */
sd_proto_pkg.sv
sd_host_pkg.sv
spi_byte_engine.sv
sd_cmd_engine.sv
sd_host_ctrl.sv
sd_spi_host.sv
sd_card_model.sv
sd_spi_host_assert.sv
tb_sd_spi_host.sv

/* sd_spi_host.sv */
// SD card host in SPI mode, joining the sequencer, command engine and byte engine
`default_nettype none

module sd_spi_host #(
   parameter int                     POWERUP_CYCLES  = 25_000_000,
   parameter sd_host_pkg::sclk_div_t INIT_DIV        = 5'd31,
   parameter int                     ACMD41_RETRIES  = 255,
   parameter int                     RESP_POLL_LIMIT = 8
) (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   r_block_i,
   input  wire logic                   r_byte_i,
   input  wire sd_host_pkg::blk_addr_t block_addr_i,
   input  wire sd_host_pkg::sclk_div_t sclk_div_i,
   output logic                        busy_o,
   output logic                        err_o,
   output logic                        byte_valid_o,
   output sd_host_pkg::byte_t          data_o,
   input  wire logic                   miso_i,
   output logic                        mosi_o,
   output logic                        sclk_o,
   output logic                        ss_o
);
   import sd_host_pkg::*;

   logic      spi_start;
   byte_t     spi_tx;
   sclk_div_t spi_div;
   logic      spi_done;
   byte_t     spi_rx;
   logic      cmd_start;
   cmd_req_t  cmd_req;
   logic      cmd_done;
   byte_t     cmd_r1;
   logic      cmd_spi_start;
   byte_t     cmd_spi_tx;
   logic      cmd_spi_done;
   byte_t     cmd_spi_rx;

   sd_host_ctrl #(
      .POWERUP_CYCLES (POWERUP_CYCLES),
      .INIT_DIV       (INIT_DIV),
      .ACMD41_RETRIES (ACMD41_RETRIES)
   ) ctrl_inst (
      .clk             (clk),
      .reset           (reset),
      .r_block_i       (r_block_i),
      .r_byte_i        (r_byte_i),
      .block_addr_i    (block_addr_i),
      .sclk_div_i      (sclk_div_i),
      .busy_o          (busy_o),
      .err_o           (err_o),
      .byte_valid_o    (byte_valid_o),
      .data_o          (data_o),
      .ss_o            (ss_o),
      .spi_start_o     (spi_start),
      .spi_tx_o        (spi_tx),
      .spi_div_o       (spi_div),
      .spi_done_i      (spi_done),
      .spi_rx_i        (spi_rx),
      .cmd_start_o     (cmd_start),
      .cmd_req_o       (cmd_req),
      .cmd_done_i      (cmd_done),
      .cmd_r1_i        (cmd_r1),
      .cmd_spi_start_i (cmd_spi_start),
      .cmd_spi_tx_i    (cmd_spi_tx),
      .cmd_spi_done_o  (cmd_spi_done),
      .cmd_spi_rx_o    (cmd_spi_rx)
   );

   // the R7 trailer of CMD8 is not checked by the sequencer
   sd_cmd_engine #(
      .RESP_POLL_LIMIT (RESP_POLL_LIMIT)
   ) cmd_inst (
      .clk         (clk),
      .reset       (reset),
      .start_i     (cmd_start),
      .req_i       (cmd_req),
      .done_o      (cmd_done),
      .r1_o        (cmd_r1),
      .trailer_o   (),
      .spi_start_o (cmd_spi_start),
      .spi_tx_o    (cmd_spi_tx),
      .spi_done_i  (cmd_spi_done),
      .spi_rx_i    (cmd_spi_rx)
   );

   spi_byte_engine byte_inst (
      .clk     (clk),
      .reset   (reset),
      .start_i (spi_start),
      .tx_i    (spi_tx),
      .div_i   (spi_div),
      .rx_o    (spi_rx),
      .done_o  (spi_done),
      .busy_o  (),
      .miso_i  (miso_i),
      .mosi_o  (mosi_o),
      .sclk_o  (sclk_o)
   );

endmodule

`default_nettype wire

/* sd_spi_host_assert.sv */
// bound checks on the SD host handshake, the error latch and chip select at power-up
`default_nettype none

module sd_spi_host_assert (
   input wire logic clk,
   input wire logic reset,
   input wire logic busy_i,
   input wire logic err_i,
   input wire logic byte_valid_i,
   input wire logic ss_i,
   input wire logic sclk_i
);
   logic [15:0] rise_cnt;
   logic        sclk_q;

   // sclk rising edges since reset
   always_ff @(posedge clk)
   begin
      sclk_q <= sclk_i;
      if (reset)
         rise_cnt <= '0;
      else if (sclk_i && !sclk_q && rise_cnt != 16'hFFFF)
         rise_cnt <= rise_cnt + 16'd1;
   end

   valid_not_busy: assert property (@(posedge clk) disable iff (reset)
      !(byte_valid_i && busy_i))
      else $error("byte_valid_o and busy_o high together");

   err_sticky: assert property (@(posedge clk) disable iff (reset) err_i |=> err_i)
      else $error("err_o dropped without reset");

   ss_after_idle_clks: assert property (@(posedge clk) disable iff (reset)
      $fell(ss_i) |-> rise_cnt >= 16'd80)
      else $error("ss_o fell before 80 idle clocks");

endmodule

bind sd_spi_host sd_spi_host_assert assert_inst (
   .clk          (clk),
   .reset        (reset),
   .busy_i       (busy_o),
   .err_i        (err_o),
   .byte_valid_i (byte_valid_o),
   .ss_i         (ss_o),
   .sclk_i       (sclk_o)
);

`default_nettype wire

/* spi_byte_engine.sv */
// SPI mode-0 master that exchanges one byte per start at a runtime clock divider
`default_nettype none

module spi_byte_engine (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   start_i,
   input  wire sd_host_pkg::byte_t     tx_i,
   input  wire sd_host_pkg::sclk_div_t div_i,
   output sd_host_pkg::byte_t          rx_o,
   output logic                        done_o,
   output logic                        busy_o,
   input  wire logic                   miso_i,
   output logic                        mosi_o,
   output logic                        sclk_o
);
   import sd_host_pkg::*;

   sclk_div_t  div_q;
   sclk_div_t  half_cnt;
   logic [3:0] edge_cnt;
   byte_t      tx_sh;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy_o   <= 1'b0;
         done_o   <= 1'b0;
         sclk_o   <= 1'b0;
         mosi_o   <= 1'b1;
         half_cnt <= '0;
         edge_cnt <= '0;
      end
      else
      begin
         done_o <= 1'b0;
         if (!busy_o)
         begin
            if (start_i)
            begin
               busy_o   <= 1'b1;
               div_q    <= div_i;
               half_cnt <= '0;
               edge_cnt <= '0;
               // msb goes out ahead of the first rising edge
               mosi_o   <= tx_i[7];
               tx_sh    <= {tx_i[6:0], 1'b1};
            end
         end
         else if (half_cnt == div_q)
         begin
            half_cnt <= '0;
            sclk_o   <= ~sclk_o;
            edge_cnt <= edge_cnt + 4'd1;
            if (!sclk_o)
            begin
               rx_o <= {rx_o[6:0], miso_i};
            end
            else
            begin
               // ones shift in, so mosi rests high after the byte
               mosi_o <= tx_sh[7];
               tx_sh  <= {tx_sh[6:0], 1'b1};
               if (edge_cnt == 4'd15)
               begin
                  busy_o <= 1'b0;
                  done_o <= 1'b1;
               end
            end
         end
         else
         begin
            half_cnt <= half_cnt + 5'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* tb_sd_spi_host.sv */
// testbench for the SD SPI host: identification, block reads and ACMD41 timeout against a card model
`default_nettype none

module tb_sd_spi_host;
   import sd_proto_pkg::*;
   import sd_host_pkg::*;

   localparam int POWERUP_CYCLES = 200;
   localparam int INIT_DIV       = 31;
   localparam int RETRIES        = 3;
   localparam int N_BLOCKS       = 3;
   // generous byte counts per identification and per block read
   localparam int INIT_BYTES  = 10 + 2 * 20 + 2 * RETRIES * 20;
   localparam int READ_BYTES  = 20 + BLOCK_BYTES + CRC_BYTES;
   localparam int CYCLE_LIMIT = 2 * POWERUP_CYCLES
                                + (2 * INIT_BYTES + N_BLOCKS * READ_BYTES) * 16 * (INIT_DIV + 1)
                                + N_BLOCKS * BLOCK_BYTES * 10 + 5000;

   logic       clk = 1'b0;
   logic       reset;
   logic       r_block;
   logic       r_byte;
   blk_addr_t  block_addr;
   sclk_div_t  sclk_div;
   logic       busy;
   logic       err;
   logic       byte_valid;
   byte_t      data;
   logic       miso;
   logic       mosi;
   logic       sclk;
   logic       ss;
   logic [7:0] acmd41_busy;
   logic [31:0] lfsr;
   logic       div_check = 1'b0;
   int         exp_div = 0;
   int         high_cnt = 0;
   int         cycles = 0;

   sd_spi_host #(
      .POWERUP_CYCLES (POWERUP_CYCLES),
      .INIT_DIV       (5'(INIT_DIV)),
      .ACMD41_RETRIES (RETRIES)
   ) sd_spi_host_inst (
      .clk          (clk),
      .reset        (reset),
      .r_block_i    (r_block),
      .r_byte_i     (r_byte),
      .block_addr_i (block_addr),
      .sclk_div_i   (sclk_div),
      .busy_o       (busy),
      .err_o        (err),
      .byte_valid_o (byte_valid),
      .data_o       (data),
      .miso_i       (miso),
      .mosi_o       (mosi),
      .sclk_o       (sclk),
      .ss_o         (ss)
   );

   sd_card_model card_inst (
      .reset_i       (reset),
      .ss_i          (ss),
      .sclk_i        (sclk),
      .mosi_i        (mosi),
      .acmd41_busy_i (acmd41_busy),
      .miso_o        (miso)
   );

   always #2 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
         abort_run($sformatf("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp));
   endtask

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic byte_t expected_byte(input blk_addr_t a, input int i);
      logic [31:0] sum;
      sum = a * 32'd7 + 32'(i) * 32'd13;
      return sum[7:0];
   endfunction

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
         abort_run("timeout: the DUT did not finish within the cycle limit");
   end

   // high phase of sclk, counted in clk cycles
   always @(posedge clk)
   begin
      if (sclk)
         high_cnt <= high_cnt + 1;
      else
      begin
         if (div_check && high_cnt != 0)
            check_value("sclk half period", 64'(high_cnt), 64'(exp_div + 1));
         high_cnt <= 0;
      end
   end

   task automatic reset_dut(input logic [7:0] busy_cnt, input sclk_div_t div);
      @(negedge clk);
      reset       = 1'b1;
      r_block     = 1'b0;
      r_byte      = 1'b0;
      acmd41_busy = busy_cnt;
      sclk_div    = div;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      check_value("ss_o after reset", 64'(ss), 64'd1);
      check_value("busy_o after reset", 64'(busy), 64'd1);
   endtask

   task automatic check_init(input int busy_cnt);
      sd_frame_t f;
      int        n;
      while (busy)
         @(negedge clk);
      check_value("err_o after init", 64'(err), 64'd0);
      check_value("80 idle clocks seen", 64'(card_inst.init_clks >= 80), 64'd1);
      n = card_inst.frames.size();
      check_value("frames during init", 64'(n), 64'(2 + 2 * (busy_cnt + 1)));
      f = card_inst.frames[0];
      check_value("first frame", {f.idx, f.crc}, {CMD_GO_IDLE, CRC_CMD0});
      f = card_inst.frames[1];
      check_value("second frame", {f.idx, f.arg, f.crc}, {CMD_SEND_IF_COND, ARG_IF_COND, CRC_CMD8});
      for (int k = 2; k < n; k++)
      begin
         f = card_inst.frames[k];
         check_value($sformatf("frame %0d index", k), 64'(f.idx),
                     64'((k % 2 == 0) ? CMD_APP : ACMD_SEND_OP_COND));
      end
   endtask

   task automatic read_block(input blk_addr_t addr);
      logic [31:0] delay;
      byte_t       held;
      sd_frame_t   f;
      @(negedge clk);
      r_block    = 1'b1;
      block_addr = addr;
      @(negedge clk);
      r_block = 1'b0;
      for (int i = 0; i < BLOCK_BYTES; i++)
      begin
         while (!byte_valid)
            @(negedge clk);
         held = data;
         check_value($sformatf("byte %0d of block %0h", i, addr), 64'(data),
                     64'(expected_byte(addr, i)));
         take_bits(3, delay);
         repeat (delay)
         begin
            @(negedge clk);
            check_value("byte_valid_o while waiting", 64'(byte_valid), 64'd1);
            check_value("data_o while valid", 64'(data), 64'(held));
         end
         r_byte = 1'b1;
         @(negedge clk);
         r_byte = 1'b0;
      end
      while (busy)
         @(negedge clk);
      check_value("byte_valid_o in idle", 64'(byte_valid), 64'd0);
      f = card_inst.frames[card_inst.frames.size() - 1];
      check_value("read command", {f.idx, f.arg}, {CMD_READ_SINGLE, addr});
   endtask

   initial
   begin
      logic [31:0] v;
      logic [7:0]  busy_cnt;
      sclk_div_t   div;
      sd_frame_t   f;
      int          acmd41_seen;
      reset       = 1'b1;
      r_block     = 1'b0;
      r_byte      = 1'b0;
      block_addr  = '0;
      sclk_div    = '0;
      acmd41_busy = '0;
      lfsr        = 32'hec44;

      take_bits(2, v);
      div = v[4:0];
      take_bits(1, v);
      busy_cnt = v[7:0] + 8'd1;
      reset_dut(busy_cnt, div);
      check_init(int'(busy_cnt));

      exp_div   = int'(div);
      div_check = 1'b1;
      repeat (N_BLOCKS)
      begin
         take_bits(32, v);
         read_block(v);
      end
      div_check = 1'b0;

      // card stays busy past the retry limit
      reset_dut(8'(RETRIES + 5), div);
      while (!err)
         @(negedge clk);
      check_value("busy_o in error", 64'(busy), 64'd1);
      r_block = 1'b1;
      repeat (50) @(negedge clk);
      r_block = 1'b0;
      check_value("err_o held", 64'(err), 64'd1);
      acmd41_seen = 0;
      for (int k = 0; k < card_inst.frames.size(); k++)
      begin
         f = card_inst.frames[k];
         check_value("no read after error", 64'(f.idx == CMD_READ_SINGLE), 64'd0);
         if (f.idx == ACMD_SEND_OP_COND)
            acmd41_seen++;
      end
      check_value("ACMD41 tries before error", 64'(acmd41_seen), 64'(RETRIES));

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire
